// File: design/audioPkg.sv
package audioPkg;

    // ************************************************************
    // engine constants
    // ************************************************************

    localparam int NUM_VOICES   = 4;
    localparam int MEM_DEPTH    = 4096;
    localparam int UNITY_VOLUME = 128;

    // gain is in units of 1/128, so the product is shifted down by 7
    localparam int VOLUME_SHIFT = 7;

    // four 16-bit voices need 18 bits, one spare bit on top
    localparam int MIX_WIDTH    = 19;

    // ************************************************************
    // word types
    // ************************************************************

    typedef logic signed [15:0] tSample;
    typedef logic        [11:0] tMemAddr;
    typedef logic        [23:0] tPosition;
    typedef logic        [7:0]  tVolume;
    typedef logic        [23:0] tRegData;
    typedef logic        [1:0]  tVoiceIdx;

    localparam tSample SAMPLE_MAX = 16'sh7FFF;
    localparam tSample SAMPLE_MIN = 16'sh8000;

    // register selects of a voice
    typedef enum logic [3:0] {
        IDLE            = 4'd0,
        SET_START       = 4'd1,
        SET_COUNT       = 4'd2,
        SET_LOOP_START  = 4'd3,
        SET_LOOP_END    = 4'd4,
        SET_POSITION    = 4'd5,
        SET_LAST_SAMPLE = 4'd6,
        SET_VOLUME      = 4'd7,
        SET_LOOPING     = 4'd8,
        SET_PLAYING     = 4'd9,
        SET_MONO        = 4'd10,
        SET_RIGHT       = 4'd11
    } tVoiceSetting;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_DATA,
        FETCH_MIX
    } tFetchState;

endpackage

// File: design/sampleMemory.sv
`timescale 1ns/1ps

module sampleMemory
    import audioPkg::*;
(
    input  logic    clk,

    input  logic    i_writeEnable,
    input  tMemAddr i_writeAddr,
    input  tSample  i_writeData,

    input  tMemAddr i_readAddr,
    output tSample  o_readData
);

    tSample mem [MEM_DEPTH];

    // read and write share one block so a collision returns the old word
    always_ff @(posedge clk) begin
        if (i_writeEnable) begin
            mem[i_writeAddr] <= i_writeData;
        end
        o_readData <= mem[i_readAddr];
    end

endmodule

// File: design/fetchSequencer.sv
`timescale 1ns/1ps

module fetchSequencer
    import audioPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  i_frameTick,
    input  tMemAddr               i_voiceAddr [NUM_VOICES],

    output tMemAddr               o_readAddr,
    output logic [NUM_VOICES-1:0] o_ready,
    output logic                  o_mixStrobe
);

    tFetchState state;
    tFetchState stateNext;
    tVoiceIdx   voiceIdx;
    logic       lastVoice;

    assign lastVoice = (voiceIdx == tVoiceIdx'(NUM_VOICES - 1));

    // ************************************************************
    // state machine
    // ************************************************************

    always_comb begin
        stateNext = state;
        case (state)
            FETCH_IDLE: begin
                if (i_frameTick) begin
                    stateNext = FETCH_ADDR;
                end
            end
            FETCH_ADDR: begin
                stateNext = FETCH_DATA;
            end
            FETCH_DATA: begin
                stateNext = lastVoice ? FETCH_MIX : FETCH_ADDR;
            end
            FETCH_MIX: begin
                stateNext = FETCH_IDLE;
            end
            default: begin
                stateNext = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= FETCH_IDLE;
            voiceIdx <= '0;
        end else begin
            state <= stateNext;
            if (state == FETCH_IDLE) begin
                voiceIdx <= '0;
            end else if (state == FETCH_DATA && !lastVoice) begin
                voiceIdx <= voiceIdx + 2'd1;
            end
        end
    end

    // ************************************************************
    // outputs
    // ************************************************************

    // the address stays on the bus through the data cycle, memory reads it in the address cycle
    assign o_readAddr = i_voiceAddr[voiceIdx];

    always_comb begin
        o_ready = '0;
        if (state == FETCH_DATA) begin
            o_ready[voiceIdx] = 1'b1;
        end
    end

    assign o_mixStrobe = (state == FETCH_MIX);

endmodule

// File: design/sampleVoice.sv
`timescale 1ns/1ps

module sampleVoice
    import audioPkg::*;
#(
    parameter int VOICE_INDEX = 0
) (
    input  logic         clk,
    input  logic         rst,

    input  logic         i_regWrite,
    input  tVoiceIdx     i_regVoice,
    input  tVoiceSetting i_regSelect,
    input  tRegData      i_regData,

    input  logic         i_ready,
    input  tSample       i_sample,

    output tMemAddr      o_nextAddress,
    output tSample       o_sampleOut,
    output logic         o_isMono,
    output logic         o_isRight,
    output logic         o_isPlaying
);

    tMemAddr  startAddr;
    tPosition sampleCount;
    tPosition loopStart;
    tPosition loopEnd;
    tPosition position;
    tSample   lastSample;
    tVolume   volume;
    logic     isLooping;
    logic     isPlaying;
    logic     isMono;
    logic     isRight;

    logic     regHit;
    tPosition positionPlus1;
    tPosition nextPosition;
    tMemAddr  addrMono;
    tMemAddr  addrLeft;
    tMemAddr  addrRight;

    logic signed [$bits(tSample)+$bits(tVolume):0] product;
    logic signed [$bits(tSample)+$bits(tVolume):0] scaled;

    function automatic tSample clampScaled(input logic signed [$bits(product)-1:0] value);
        if (value > SAMPLE_MAX) begin
            return SAMPLE_MAX;
        end else if (value < SAMPLE_MIN) begin
            return SAMPLE_MIN;
        end
        return tSample'(value);
    endfunction

    assign regHit = i_regWrite && (i_regVoice == tVoiceIdx'(VOICE_INDEX));

    // ************************************************************
    // next memory address
    // ************************************************************

    // stereo data is interleaved, left word first, and all sums wrap at 12 bits
    assign addrMono  = startAddr + position[11:0] + 12'd1;
    assign addrLeft  = startAddr + {position[10:0], 1'b0} + 12'd2;
    assign addrRight = startAddr + {position[10:0], 1'b0} + 12'd3;

    assign o_nextAddress = isMono  ? addrMono  :
                           isRight ? addrRight : addrLeft;

    assign positionPlus1 = position + 24'd1;
    assign nextPosition  = (isLooping && positionPlus1 >= loopEnd) ? loopStart : positionPlus1;

    // ************************************************************
    // gain stage
    // ************************************************************

    assign product = lastSample * $signed({1'b0, volume});
    assign scaled  = product >>> VOLUME_SHIFT;

    assign o_sampleOut = isPlaying ? clampScaled(scaled) : '0;
    assign o_isMono    = isMono;
    assign o_isRight   = isRight;
    assign o_isPlaying = isPlaying;

    always_ff @(posedge clk) begin
        if (rst) begin
            startAddr   <= '0;
            sampleCount <= '0;
            loopStart   <= '0;
            loopEnd     <= '0;
            position    <= '0;
            lastSample  <= '0;
            volume      <= tVolume'(UNITY_VOLUME);
            isLooping   <= 1'b0;
            isPlaying   <= 1'b0;
            isMono      <= 1'b1;
            isRight     <= 1'b0;
        end else begin
            if (i_ready && isPlaying) begin
                lastSample <= i_sample;
                position   <= nextPosition;
            end

            // a host write lands after the ready update so it wins
            if (regHit) begin
                case (i_regSelect)
                    SET_START:       startAddr   <= i_regData[11:0];
                    SET_COUNT:       sampleCount <= i_regData;
                    SET_LOOP_START:  loopStart   <= i_regData;
                    SET_LOOP_END:    loopEnd     <= i_regData;
                    SET_POSITION:    position    <= i_regData;
                    SET_LAST_SAMPLE: lastSample  <= tSample'(i_regData[15:0]);
                    SET_VOLUME:      volume      <= i_regData[7:0];
                    SET_LOOPING:     isLooping   <= i_regData[0];
                    SET_PLAYING:     isPlaying   <= i_regData[0];
                    SET_MONO:        isMono      <= i_regData[0];
                    SET_RIGHT:       isRight     <= i_regData[0];
                    default: begin
                    end
                endcase
            end

            // end of sample data stops the voice even against a play write
            if (position >= sampleCount) begin
                isPlaying <= 1'b0;
            end
        end
    end

endmodule

// File: design/stereoMixer.sv
`timescale 1ns/1ps

module stereoMixer
    import audioPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  i_mixStrobe,
    input  tSample                i_voiceSample [NUM_VOICES],
    input  logic [NUM_VOICES-1:0] i_voiceMono,
    input  logic [NUM_VOICES-1:0] i_voiceRight,

    output tSample                o_left,
    output tSample                o_right,
    output logic                  o_frameValid
);

    logic signed [MIX_WIDTH-1:0] leftSum;
    logic signed [MIX_WIDTH-1:0] rightSum;

    function automatic tSample clampMix(input logic signed [MIX_WIDTH-1:0] sum);
        if (sum > SAMPLE_MAX) begin
            return SAMPLE_MAX;
        end else if (sum < SAMPLE_MIN) begin
            return SAMPLE_MIN;
        end
        return tSample'(sum);
    endfunction

    // ************************************************************
    // routing and summing
    // ************************************************************

    // a mono voice goes to both sides
    always_comb begin
        leftSum  = '0;
        rightSum = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (i_voiceMono[v] || !i_voiceRight[v]) begin
                leftSum = leftSum + i_voiceSample[v];
            end
            if (i_voiceMono[v] || i_voiceRight[v]) begin
                rightSum = rightSum + i_voiceSample[v];
            end
        end
    end

    // ************************************************************
    // frame output register
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            o_left       <= '0;
            o_right      <= '0;
            o_frameValid <= 1'b0;
        end else begin
            o_frameValid <= i_mixStrobe;
            if (i_mixStrobe) begin
                o_left  <= clampMix(leftSum);
                o_right <= clampMix(rightSum);
            end
        end
    end

endmodule

// File: design/audioEngine.sv
`timescale 1ns/1ps

module audioEngine
    import audioPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // host side of the sample memory
    input  logic                  i_memWrite,
    input  tMemAddr               i_memAddr,
    input  tSample                i_memData,

    // host side of the voice registers
    input  logic                  i_regWrite,
    input  tVoiceIdx              i_regVoice,
    input  tVoiceSetting          i_regSelect,
    input  tRegData               i_regData,

    input  logic                  i_frameTick,

    output tSample                o_left,
    output tSample                o_right,
    output logic                  o_frameValid,
    output logic [NUM_VOICES-1:0] o_playing
);

    tMemAddr               voiceAddr [NUM_VOICES];
    tSample                voiceSample [NUM_VOICES];
    logic [NUM_VOICES-1:0] voiceMono;
    logic [NUM_VOICES-1:0] voiceRight;
    logic [NUM_VOICES-1:0] voiceReady;
    tMemAddr               readAddr;
    tSample                readData;
    logic                  mixStrobe;

    sampleMemory memory_i (
        .clk           (clk),
        .i_writeEnable (i_memWrite),
        .i_writeAddr   (i_memAddr),
        .i_writeData   (i_memData),
        .i_readAddr    (readAddr),
        .o_readData    (readData)
    );

    fetchSequencer sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .i_frameTick (i_frameTick),
        .i_voiceAddr (voiceAddr),
        .o_readAddr  (readAddr),
        .o_ready     (voiceReady),
        .o_mixStrobe (mixStrobe)
    );

    // ************************************************************
    // voice bank
    // ************************************************************

    // every voice sees the shared read data, only the one with ready takes it
    for (genvar v = 0; v < NUM_VOICES; v++) begin : gVoice
        sampleVoice #(
            .VOICE_INDEX (v)
        ) voice_i (
            .clk           (clk),
            .rst           (rst),
            .i_regWrite    (i_regWrite),
            .i_regVoice    (i_regVoice),
            .i_regSelect   (i_regSelect),
            .i_regData     (i_regData),
            .i_ready       (voiceReady[v]),
            .i_sample      (readData),
            .o_nextAddress (voiceAddr[v]),
            .o_sampleOut   (voiceSample[v]),
            .o_isMono      (voiceMono[v]),
            .o_isRight     (voiceRight[v]),
            .o_isPlaying   (o_playing[v])
        );
    end

    stereoMixer mixer_i (
        .clk           (clk),
        .rst           (rst),
        .i_mixStrobe   (mixStrobe),
        .i_voiceSample (voiceSample),
        .i_voiceMono   (voiceMono),
        .i_voiceRight  (voiceRight),
        .o_left        (o_left),
        .o_right       (o_right),
        .o_frameValid  (o_frameValid)
    );

endmodule

// File: verification/audioEngineTb.sv
`timescale 1ns/1ps

module audioEngineTb
    import audioPkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_WAIT   = 12;
    localparam int SEED         = 69162;

    localparam int ROW_MEM   = 0;
    localparam int ROW_REG   = 1;
    localparam int ROW_FRAME = 2;

    logic                  clk;
    logic                  rst;
    logic                  i_memWrite;
    tMemAddr               i_memAddr;
    tSample                i_memData;
    logic                  i_regWrite;
    tVoiceIdx              i_regVoice;
    tVoiceSetting          i_regSelect;
    tRegData               i_regData;
    logic                  i_frameTick;
    tSample                o_left;
    tSample                o_right;
    logic                  o_frameValid;
    logic [NUM_VOICES-1:0] o_playing;

    audioEngine audioEngine_i (
        .clk          (clk),
        .rst          (rst),
        .i_memWrite   (i_memWrite),
        .i_memAddr    (i_memAddr),
        .i_memData    (i_memData),
        .i_regWrite   (i_regWrite),
        .i_regVoice   (i_regVoice),
        .i_regSelect  (i_regSelect),
        .i_regData    (i_regData),
        .i_frameTick  (i_frameTick),
        .o_left       (o_left),
        .o_right      (o_right),
        .o_frameValid (o_frameValid),
        .o_playing    (o_playing)
    );

    // one row per operation, frame rows carry the expected outputs
    int rowKind[$];
    int rowTarget[$];
    int rowSelect[$];
    int rowData[$];
    int expLeft[$];
    int expRight[$];
    int expPlaying[$];

    // behavioral model of the memory and the voices
    tSample memModel [MEM_DEPTH];
    int vStart [NUM_VOICES];
    int vCount [NUM_VOICES];
    int vLoopStart [NUM_VOICES];
    int vLoopEnd [NUM_VOICES];
    int vPos [NUM_VOICES];
    int vLast [NUM_VOICES];
    int vVolume [NUM_VOICES];
    int vLooping [NUM_VOICES];
    int vPlaying [NUM_VOICES];
    int vMono [NUM_VOICES];
    int vRight [NUM_VOICES];

    int mismatches  = 0;
    int otherErrors = 0;
    int cycleCount  = 0;
    int cycleLimit  = 0;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int saturate16(input int value);
        if (value > 32767) begin
            return 32767;
        end else if (value < -32768) begin
            return -32768;
        end
        return value;
    endfunction

    // ************************************************************
    // table construction and model
    // ************************************************************

    task automatic pushRow(input int kind, input int target, input int sel, input int data,
                           input int left, input int right, input int playing);
        rowKind.push_back(kind);
        rowTarget.push_back(target);
        rowSelect.push_back(sel);
        rowData.push_back(data);
        expLeft.push_back(left);
        expRight.push_back(right);
        expPlaying.push_back(playing);
    endtask

    task automatic resetModel();
        for (int v = 0; v < NUM_VOICES; v++) begin
            vStart[v]     = 0;
            vCount[v]     = 0;
            vLoopStart[v] = 0;
            vLoopEnd[v]   = 0;
            vPos[v]       = 0;
            vLast[v]      = 0;
            vVolume[v]    = UNITY_VOLUME;
            vLooping[v]   = 0;
            vPlaying[v]   = 0;
            vMono[v]      = 1;
            vRight[v]     = 0;
        end
    endtask

    task automatic addMemWrite(input int addr, input int data);
        memModel[addr & (MEM_DEPTH - 1)] = tSample'(data);
        pushRow(ROW_MEM, addr, 0, data, 0, 0, 0);
    endtask

    task automatic addRegWrite(input int v, input tVoiceSetting sel, input int data);
        case (sel)
            SET_START:       vStart[v]     = data & 'hFFF;
            SET_COUNT:       vCount[v]     = data & 'hFFFFFF;
            SET_LOOP_START:  vLoopStart[v] = data & 'hFFFFFF;
            SET_LOOP_END:    vLoopEnd[v]   = data & 'hFFFFFF;
            SET_POSITION:    vPos[v]       = data & 'hFFFFFF;
            SET_LAST_SAMPLE: vLast[v]      = int'(tSample'(data[15:0]));
            SET_VOLUME:      vVolume[v]    = data & 'hFF;
            SET_LOOPING:     vLooping[v]   = data & 1;
            SET_PLAYING:     vPlaying[v]   = data & 1;
            SET_MONO:        vMono[v]      = data & 1;
            SET_RIGHT:       vRight[v]     = data & 1;
            default: begin
            end
        endcase
        if (vPos[v] >= vCount[v]) begin
            vPlaying[v] = 0;
        end
        pushRow(ROW_REG, v, int'(sel), data, 0, 0, 0);
    endtask

    task automatic addFrame();
        int addr;
        int outv;
        int sumL;
        int sumR;
        int bits;
        sumL = 0;
        sumR = 0;
        bits = 0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (vPlaying[v] != 0) begin
                if (vMono[v] != 0) begin
                    addr = vStart[v] + vPos[v] + 1;
                end else if (vRight[v] != 0) begin
                    addr = vStart[v] + 2 * vPos[v] + 3;
                end else begin
                    addr = vStart[v] + 2 * vPos[v] + 2;
                end
                vLast[v] = int'(memModel[addr & (MEM_DEPTH - 1)]);
                if (vLooping[v] != 0 && vPos[v] + 1 >= vLoopEnd[v]) begin
                    vPos[v] = vLoopStart[v];
                end else begin
                    vPos[v] = (vPos[v] + 1) & 'hFFFFFF;
                end
                if (vPos[v] >= vCount[v]) begin
                    vPlaying[v] = 0;
                end
            end
            outv = 0;
            if (vPlaying[v] != 0) begin
                // gain is in units of 1/128
                outv = saturate16((vLast[v] * vVolume[v]) >>> 7);
                bits = bits | (1 << v);
            end
            if (vMono[v] != 0 || vRight[v] == 0) begin
                sumL = sumL + outv;
            end
            if (vMono[v] != 0 || vRight[v] != 0) begin
                sumR = sumR + outv;
            end
        end
        pushRow(ROW_FRAME, 0, 0, 0, saturate16(sumL), saturate16(sumR), bits);
    endtask

    task automatic fillRandom(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            addMemWrite(base + i, int'($urandom() & 'hFFFF));
        end
    endtask

    // position is cleared before play so the voice starts at its first word
    task automatic configVoice(input int v, input int start, input int count,
                               input int mono, input int right);
        addRegWrite(v, SET_START, start);
        addRegWrite(v, SET_COUNT, count);
        addRegWrite(v, SET_POSITION, 0);
        addRegWrite(v, SET_VOLUME, UNITY_VOLUME);
        addRegWrite(v, SET_LOOPING, 0);
        addRegWrite(v, SET_MONO, mono);
        addRegWrite(v, SET_RIGHT, right);
        addRegWrite(v, SET_PLAYING, 1);
    endtask

    task automatic buildTable();
        int mixedWord [NUM_VOICES] = '{'h4000, 'hD000, 'h2000, 'hE800};
        repeat (2) addFrame();
        addRegWrite(3, SET_COUNT, 0);
        addRegWrite(3, SET_PLAYING, 1);
        addFrame();

        fillRandom('h100, 16);
        configVoice(0, 'h100, 5, 1, 0);
        repeat (7) addFrame();

        // words near full scale for the gain checks
        addMemWrite('h200, 'h7F00);
        addMemWrite('h201, 'h8100);
        addMemWrite('h202, 'h1235);
        addMemWrite('h203, 'hFFFF);
        addMemWrite('h204, 'h8000);
        addMemWrite('h205, 'h0100);
        configVoice(1, 'h1FF, 6, 1, 0);
        addRegWrite(1, SET_VOLUME, 255);
        repeat (2) addFrame();
        addRegWrite(1, SET_VOLUME, 64);
        repeat (4) addFrame();

        fillRandom('h300, 16);
        configVoice(0, 'h2FE, 5, 0, 0);
        configVoice(2, 'h2FE, 5, 0, 1);
        repeat (6) addFrame();

        configVoice(2, 'h0FF, 6, 1, 0);
        addRegWrite(2, SET_LOOP_START, 1);
        addRegWrite(2, SET_LOOP_END, 4);
        addRegWrite(2, SET_LOOPING, 1);
        repeat (8) addFrame();
        addRegWrite(2, SET_POSITION, 5);
        repeat (2) addFrame();
        addRegWrite(2, SET_LOOPING, 0);
        repeat (5) addFrame();

        // first two frames saturate, the last two sum exactly
        for (int v = 0; v < NUM_VOICES; v++) begin
            addMemWrite('h400 + 16 * v, 'h5000 + 'h100 * v);
            addMemWrite('h401 + 16 * v, 'hB000 - 'h100 * v);
            addMemWrite('h402 + 16 * v, mixedWord[v]);
            addMemWrite('h403 + 16 * v, int'($urandom() & 'h1FFF) - 'h1000);
            configVoice(v, 'h3FF + 16 * v, 100, 1, 0);
        end
        repeat (4) addFrame();
        for (int v = 0; v < NUM_VOICES; v++) begin
            addRegWrite(v, SET_PLAYING, 0);
        end
        addFrame();
    endtask

    // ************************************************************
    // row execution
    // ************************************************************

    task automatic driveMemWrite(input int addr, input int data);
        @(posedge clk);
        i_memWrite <= 1'b1;
        i_memAddr  <= tMemAddr'(addr);
        i_memData  <= tSample'(data);
        @(posedge clk);
        i_memWrite <= 1'b0;
    endtask

    task automatic driveRegWrite(input int v, input int sel, input int data);
        @(posedge clk);
        i_regWrite  <= 1'b1;
        i_regVoice  <= tVoiceIdx'(v);
        i_regSelect <= tVoiceSetting'(sel[3:0]);
        i_regData   <= tRegData'(data);
        @(posedge clk);
        i_regWrite <= 1'b0;
    endtask

    task automatic runFrame(input int idx);
        logic [NUM_VOICES-1:0] expBits;
        int                    waited;
        logic                  seen;
        expBits = NUM_VOICES'(expPlaying[idx]);
        @(posedge clk);
        i_frameTick <= 1'b1;
        @(posedge clk);
        i_frameTick <= 1'b0;
        waited = 0;
        seen   = 1'b0;
        // outputs are read on the falling edge, away from the update edge
        while (!seen && waited < FRAME_WAIT) begin
            @(negedge clk);
            waited++;
            seen = o_frameValid;
        end
        if (!seen) begin
            $display("row %0d: no frame valid pulse within %0d cycles of the tick", idx, FRAME_WAIT);
            otherErrors++;
        end else begin
            if (o_left !== tSample'(expLeft[idx])) begin
                $display("Mismatch row %0d o_left: got %h, expected %h",
                         idx, o_left, tSample'(expLeft[idx]));
                mismatches++;
            end
            if (o_right !== tSample'(expRight[idx])) begin
                $display("Mismatch row %0d o_right: got %h, expected %h",
                         idx, o_right, tSample'(expRight[idx]));
                mismatches++;
            end
            if (o_playing !== expBits) begin
                $display("Mismatch row %0d o_playing: got %h, expected %h", idx, o_playing, expBits);
                mismatches++;
            end
            // the valid flag is a single-cycle pulse
            @(negedge clk);
            if (o_frameValid !== 1'b0) begin
                $display("row %0d: frame valid stayed high for more than one cycle", idx);
                otherErrors++;
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        i_memWrite  = 1'b0;
        i_memAddr   = '0;
        i_memData   = '0;
        i_regWrite  = 1'b0;
        i_regVoice  = '0;
        i_regSelect = IDLE;
        i_regData   = '0;
        i_frameTick = 1'b0;
        resetModel();
        buildTable();
        cycleLimit = rowKind.size() * 16 + 200;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < rowKind.size(); i++) begin
            case (rowKind[i])
                ROW_MEM:  driveMemWrite(rowTarget[i], rowData[i]);
                ROW_REG:  driveRegWrite(rowTarget[i], rowSelect[i], rowData[i]);
                default:  runFrame(i);
            endcase
        end
        repeat (2) @(posedge clk);

        $display("done: %0d mismatches, %0d other errors", mismatches, otherErrors);
        if (mismatches + otherErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", cycleLimit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: sim.f
design/audioPkg.sv
design/sampleMemory.sv
design/fetchSequencer.sv
design/sampleVoice.sv
design/stereoMixer.sv
design/audioEngine.sv
verification/audioEngineTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the audio engine testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module audioEngineTb -o audioEngineSim

# the log decides the outcome, so a nonzero simulator exit does not stop here
./obj_dir/audioEngineSim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
